/* common/i2c_slave_cfg.svh */
`ifndef I2C_SLAVE_CFG_SVH
`define I2C_SLAVE_CFG_SVH

// Length of the SCL/SDA glitch filter chain
`define I2C_GLITCH 6

// Clocks from SCL fall to ACK release
`define I2C_ACK_HOLD 6'd8

// General call
`define I2C_GCALL_ADDR 7'h00

// Word FIFO depths
`define RX_FIFO_DEPTH 4
`define TX_FIFO_DEPTH 4

`endif

/* common/i2c_slave_pkg.sv */
package i2c_slave_pkg;

	// ---------------------------------------------------------------------
	// Protocol states
	// ---------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		ADDR  = 3'd1,  // Address byte coming in
		DWR   = 3'd2,  // Master writes data
		DRD   = 3'd3,  // Slave sends data
		ACKO  = 3'd4,  // Slave ACK after a data byte
		AACKO = 3'd5,  // Slave ACK after the address byte
		ACKI  = 3'd6   // Master ACK on reads
	} i2c_state_e;

	// ---------------------------------------------------------------------
	// Views of the low shift register byte
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic [6:0] addr;
		logic       rw;    // High for a read
	} i2c_addr_s;

	// Address view in ADDR, data view everywhere else
	typedef union packed {
		logic [7:0] data;
		i2c_addr_s  a;
	} i2c_byte_u;

endpackage

/* files.f */
+incdir+common
common/i2c_slave_pkg.sv
rtl/word_fifo.sv
i2c_slave/i2c_line_filter.sv
i2c_slave/i2c_bit_timer.sv
i2c_slave/i2c_shift_reg.sv
i2c_slave/i2c_slave_fsm.sv
rtl/i2c_slave_top.sv
verif/i2c_master_bfm.sv
verif/i2c_slave_tb.sv

/* i2c_slave/i2c_bit_timer.sv */
`timescale 1ns/1ps
`include "i2c_slave_cfg.svh"

module i2c_bit_timer (
	input  logic                      clk,
	input  logic                      rst,
	input  i2c_slave_pkg::i2c_state_e state_i,
	input  logic                      scl_fall_i,
	output logic                      byte_end_o,
	output logic                      word_end_o,
	output logic                      word_first_o,
	output logic                      hold_done_o
);
	logic [2:0] bit_cnt_q;
	logic [1:0] byte_cnt_q;   // Byte inside the 32-bit word
	logic [5:0] hold_cnt_q;
	logic       bit_state_w;
	logic       ack_state_w;

	assign bit_state_w = (state_i == i2c_slave_pkg::ADDR) ||
		(state_i == i2c_slave_pkg::DWR) ||
		(state_i == i2c_slave_pkg::DRD);
	assign ack_state_w = (state_i == i2c_slave_pkg::ACKO) ||
		(state_i == i2c_slave_pkg::AACKO);

	assign byte_end_o   = bit_state_w && scl_fall_i && (bit_cnt_q == 3'd7);
	assign word_end_o   = (byte_cnt_q == 2'd3);
	assign word_first_o = (byte_cnt_q == 2'd0);
	assign hold_done_o  = (hold_cnt_q == `I2C_ACK_HOLD);

	// Bit and byte counters
	always_ff @(posedge clk) begin
		if (rst || state_i == i2c_slave_pkg::IDLE) begin
			bit_cnt_q  <= 3'd0;
			byte_cnt_q <= 2'd0;
		end else begin
			if (bit_state_w && scl_fall_i)
				bit_cnt_q <= bit_cnt_q + 3'd1;
			if (byte_end_o && state_i != i2c_slave_pkg::ADDR)
				byte_cnt_q <= byte_cnt_q + 2'd1;  // Data bytes only
		end
	end

	// ACK hold, started by the ninth SCL fall
	always_ff @(posedge clk) begin
		if (rst)
			hold_cnt_q <= 6'd0;
		else if (ack_state_w && scl_fall_i)
			hold_cnt_q <= 6'd1;
		else if (hold_cnt_q != 6'd0 && !hold_done_o)
			hold_cnt_q <= hold_cnt_q + 6'd1;
		else
			hold_cnt_q <= 6'd0;
	end

endmodule

/* i2c_slave/i2c_line_filter.sv */
`timescale 1ns/1ps
`include "i2c_slave_cfg.svh"

module i2c_line_filter (
	input  logic clk,
	input  logic rst,
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_o,
	output logic sda_o,
	output logic start_o,
	output logic stop_o,
	output logic scl_rise_o,
	output logic scl_fall_o
);
	// Index 1 is SCL, index 0 is SDA
	logic [1:0]                   pin_w;
	logic [1:0][`I2C_GLITCH-1:0] chain_q;
	logic [1:0]                   level_q;
	logic [1:0]                   prev_q;

	assign pin_w = {scl_i, sda_i};

	always_ff @(posedge clk) begin
		if (rst) begin
			chain_q <= '1;     // Bus idles high
			level_q <= 2'b11;
			prev_q  <= 2'b11;
		end else begin
			prev_q <= level_q;
			for (int i = 0; i < 2; i++) begin
				chain_q[i] <= {chain_q[i][`I2C_GLITCH-2:0], pin_w[i]};
				// Hysteresis, level moves only when the upper taps agree
				if (&chain_q[i][`I2C_GLITCH-1:2])
					level_q[i] <= 1'b1;
				else if (~|chain_q[i][`I2C_GLITCH-1:2])
					level_q[i] <= 1'b0;
			end
		end
	end

	assign scl_o = level_q[1];
	assign sda_o = level_q[0];

	// Bus events, one clock after the filtered levels move
	always_ff @(posedge clk) begin
		if (rst) begin
			start_o    <= 1'b0;
			stop_o     <= 1'b0;
			scl_rise_o <= 1'b0;
			scl_fall_o <= 1'b0;
		end else begin
			start_o    <= prev_q[1] && prev_q[0] && level_q[1] && !level_q[0];
			stop_o     <= prev_q[1] && !prev_q[0] && level_q[1] && level_q[0];
			scl_rise_o <= !prev_q[1] && level_q[1];
			scl_fall_o <= prev_q[1] && !level_q[1];
		end
	end

endmodule

/* i2c_slave/i2c_shift_reg.sv */
`timescale 1ns/1ps
`include "i2c_slave_cfg.svh"

module i2c_shift_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  i2c_slave_pkg::i2c_state_e state_i,
	input  logic                      shift_in_i,
	input  logic                      shift_out_i,
	input  logic                      load_word_i,
	input  logic                      sda_i,
	input  logic [31:0]               tx_word_i,
	input  logic [6:0]                slave_addr_i,
	input  logic                      ack_drive_i,
	input  logic                      ack_accept_i,
	input  logic                      release_i,
	output logic [31:0]               word_o,
	output i2c_slave_pkg::i2c_byte_u  byte_o,
	output logic                      addr_hit_o,
	output logic                      sda_oe_o,
	output logic                      collision_o
);
	logic [31:0] word_q;

	// ---------------------------------------------------------------------
	// Word shifter, MSB first in both directions
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load_word_i)
			word_q <= tx_word_i;
		else if (shift_out_i)
			word_q <= {word_q[30:0], 1'b0};
		else if (shift_in_i)
			word_q <= {word_q[30:0], sda_i};
	end

	assign word_o      = word_q;
	assign byte_o.data = word_q[7:0];

	// Own address or general call
	assign addr_hit_o = (byte_o.a.addr == slave_addr_i) ||
		(byte_o.a.addr == `I2C_GCALL_ADDR);

	// ---------------------------------------------------------------------
	// SDA pull-down enable
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			sda_oe_o <= 1'b0;
		else if (release_i || state_i == i2c_slave_pkg::IDLE)
			sda_oe_o <= 1'b0;
		else if (ack_drive_i)
			sda_oe_o <= 1'b1;            // ACK low
		else if (ack_accept_i)
			sda_oe_o <= !word_q[31];     // Pull only for a zero bit
	end

	// Released line read back low means another master drove it
	assign collision_o = shift_out_i && (sda_i != !sda_oe_o);

endmodule

/* i2c_slave/i2c_slave_fsm.sv */
`timescale 1ns/1ps

module i2c_slave_fsm (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start_i,
	input  logic                      stop_i,
	input  logic                      scl_rise_i,
	input  logic                      scl_fall_i,
	input  logic                      sda_i,
	input  logic                      byte_end_i,
	input  logic                      word_end_i,
	input  logic                      word_first_i,
	input  logic                      hold_done_i,
	input  i2c_slave_pkg::i2c_byte_u  byte_i,
	input  logic                      addr_hit_i,
	input  logic                      collision_i,
	input  logic                      rx_full_i,
	input  logic                      tx_empty_i,
	output i2c_slave_pkg::i2c_state_e state_o,
	output logic                      shift_in_o,
	output logic                      shift_out_o,
	output logic                      load_word_o,
	output logic                      push_o,
	output logic                      ack_drive_o,
	output logic                      ack_accept_o,
	output logic                      release_o,
	output logic                      wr_done_o,
	output logic                      rd_done_o,
	output logic                      rd_err_o
);
	i2c_slave_pkg::i2c_state_e state_q;
	i2c_slave_pkg::i2c_state_e state_d;
	logic start_seen_q;  // START seen, first SCL fall still to come
	logic rw_q;
	logic addr_ok_q;     // Address was ACKed
	logic addr_end_w;
	logic accept_w;
	logic rd_go_w;
	logic nack_w;

	assign state_o    = state_q;
	assign addr_end_w = (state_q == i2c_slave_pkg::ADDR) && byte_end_i;

	// Back-pressure is decided here, once per transfer
	assign accept_w = addr_hit_i && (byte_i.a.rw ? !tx_empty_i : !rx_full_i);
	assign rd_go_w  = (state_q == i2c_slave_pkg::AACKO) && hold_done_i && addr_ok_q && rw_q;
	assign nack_w   = (state_q == i2c_slave_pkg::ACKI) && scl_rise_i && sda_i;

	// ---------------------------------------------------------------------
	// Next state
	// ---------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			i2c_slave_pkg::IDLE:
				if (start_seen_q && scl_fall_i)
					state_d = i2c_slave_pkg::ADDR;
			i2c_slave_pkg::ADDR:
				if (byte_end_i)
					state_d = i2c_slave_pkg::AACKO;
			i2c_slave_pkg::AACKO:
				if (hold_done_i) begin
					if (!addr_ok_q)
						state_d = i2c_slave_pkg::IDLE;
					else if (rw_q)
						state_d = i2c_slave_pkg::DRD;
					else
						state_d = i2c_slave_pkg::DWR;
				end
			i2c_slave_pkg::DWR:
				if (byte_end_i)
					state_d = i2c_slave_pkg::ACKO;
			i2c_slave_pkg::ACKO:
				if (hold_done_i)
					state_d = i2c_slave_pkg::DWR;
			i2c_slave_pkg::DRD:
				if (collision_i)
					state_d = i2c_slave_pkg::IDLE;  // Lost the bus
				else if (byte_end_i)
					state_d = i2c_slave_pkg::ACKI;
			i2c_slave_pkg::ACKI:
				if (nack_w)
					state_d = i2c_slave_pkg::IDLE;
				else if (scl_fall_i)
					state_d = i2c_slave_pkg::DRD;
			default:
				state_d = i2c_slave_pkg::IDLE;
		endcase
		if (start_i || stop_i)
			state_d = i2c_slave_pkg::IDLE;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= i2c_slave_pkg::IDLE;
			start_seen_q <= 1'b0;
			rw_q         <= 1'b0;
			addr_ok_q    <= 1'b0;
		end else begin
			state_q <= state_d;
			if (start_i)
				start_seen_q <= 1'b1;
			else if (scl_fall_i)
				start_seen_q <= 1'b0;
			if (addr_end_w) begin
				rw_q      <= byte_i.a.rw;
				addr_ok_q <= accept_w;
			end
		end
	end

	// ---------------------------------------------------------------------
	// Datapath strobes
	// ---------------------------------------------------------------------
	assign shift_in_o  = scl_rise_i && (state_q == i2c_slave_pkg::ADDR ||
		state_q == i2c_slave_pkg::DWR);
	assign shift_out_o = scl_rise_i && (state_q == i2c_slave_pkg::DRD);

	// First word on the read address, next one after the fourth ACKed byte
	assign load_word_o = (addr_end_w && accept_w && byte_i.a.rw) ||
		((state_q == i2c_slave_pkg::ACKI) && scl_rise_i && !sda_i && word_first_i);

	assign ack_drive_o = (addr_end_w && accept_w) ||
		((state_q == i2c_slave_pkg::DWR) && byte_end_i);

	// Put the next read bit on SDA while SCL is low
	assign ack_accept_o = rd_go_w ||
		((state_q == i2c_slave_pkg::DRD) && scl_fall_i && !byte_end_i) ||
		((state_q == i2c_slave_pkg::ACKI) && scl_fall_i);

	assign release_o = ((state_q == i2c_slave_pkg::AACKO) && hold_done_i && !rd_go_w) ||
		((state_q == i2c_slave_pkg::ACKO) && hold_done_i) ||
		((state_q == i2c_slave_pkg::DRD) && byte_end_i) ||
		collision_i;

	// ---------------------------------------------------------------------
	// Registered pulses
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			push_o    <= 1'b0;
			wr_done_o <= 1'b0;
			rd_done_o <= 1'b0;
			rd_err_o  <= 1'b0;
		end else begin
			push_o    <= (state_q == i2c_slave_pkg::DWR) && byte_end_i && word_end_i;
			wr_done_o <= (state_q == i2c_slave_pkg::DWR) && (start_i || stop_i);
			rd_done_o <= nack_w;
			rd_err_o  <= collision_i;
		end
	end

endmodule

/* rtl/i2c_slave_top.sv */
`timescale 1ns/1ps
`include "i2c_slave_cfg.svh"

module i2c_slave_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        scl_i,
	input  logic        sda_i,
	input  logic [6:0]  slave_addr_i,
	input  logic        rx_pop_i,
	input  logic        tx_push_i,
	input  logic [31:0] tx_data_i,
	output logic        sda_oe_o,
	output logic [31:0] rx_data_o,
	output logic        rx_empty_o,
	output logic        tx_full_o,
	output logic        wr_done_o,
	output logic        rd_done_o,
	output logic        rd_err_o
);
	logic                      sda_w;
	logic                      start_w;
	logic                      stop_w;
	logic                      scl_rise_w;
	logic                      scl_fall_w;
	i2c_slave_pkg::i2c_state_e state_w;
	logic                      byte_end_w;
	logic                      word_end_w;
	logic                      word_first_w;
	logic                      hold_done_w;
	i2c_slave_pkg::i2c_byte_u  byte_w;
	logic                      addr_hit_w;
	logic                      collision_w;
	logic                      shift_in_w;
	logic                      shift_out_w;
	logic                      load_word_w;
	logic                      push_w;
	logic                      ack_drive_w;
	logic                      ack_accept_w;
	logic                      release_w;
	logic [31:0]               word_w;
	logic [31:0]               tx_word_w;
	logic                      rx_full_w;
	logic                      tx_empty_w;

	// SCL level only matters inside the filter, the edges go out
	i2c_line_filter filter_i (
		.clk(clk), .rst(rst), .scl_i(scl_i), .sda_i(sda_i),
		.scl_o(), .sda_o(sda_w), .start_o(start_w), .stop_o(stop_w),
		.scl_rise_o(scl_rise_w), .scl_fall_o(scl_fall_w)
	);

	i2c_bit_timer timer_i (
		.clk(clk), .rst(rst), .state_i(state_w), .scl_fall_i(scl_fall_w),
		.byte_end_o(byte_end_w), .word_end_o(word_end_w),
		.word_first_o(word_first_w), .hold_done_o(hold_done_w)
	);

	i2c_shift_reg shift_i (
		.clk(clk), .rst(rst), .state_i(state_w),
		.shift_in_i(shift_in_w), .shift_out_i(shift_out_w), .load_word_i(load_word_w),
		.sda_i(sda_w), .tx_word_i(tx_word_w), .slave_addr_i(slave_addr_i),
		.ack_drive_i(ack_drive_w), .ack_accept_i(ack_accept_w), .release_i(release_w),
		.word_o(word_w), .byte_o(byte_w), .addr_hit_o(addr_hit_w),
		.sda_oe_o(sda_oe_o), .collision_o(collision_w)
	);

	i2c_slave_fsm fsm_i (
		.clk(clk), .rst(rst), .start_i(start_w), .stop_i(stop_w),
		.scl_rise_i(scl_rise_w), .scl_fall_i(scl_fall_w), .sda_i(sda_w),
		.byte_end_i(byte_end_w), .word_end_i(word_end_w), .word_first_i(word_first_w),
		.hold_done_i(hold_done_w), .byte_i(byte_w), .addr_hit_i(addr_hit_w),
		.collision_i(collision_w), .rx_full_i(rx_full_w), .tx_empty_i(tx_empty_w),
		.state_o(state_w), .shift_in_o(shift_in_w), .shift_out_o(shift_out_w),
		.load_word_o(load_word_w), .push_o(push_w), .ack_drive_o(ack_drive_w),
		.ack_accept_o(ack_accept_w), .release_o(release_w), .wr_done_o(wr_done_o),
		.rd_done_o(rd_done_o), .rd_err_o(rd_err_o)
	);

	// Bus to host
	word_fifo #(.DEPTH(`RX_FIFO_DEPTH)) rx_fifo_i (
		.clk(clk), .rst(rst), .push_i(push_w), .data_i(word_w), .pop_i(rx_pop_i),
		.data_o(rx_data_o), .full_o(rx_full_w), .empty_o(rx_empty_o)
	);

	// Host to bus, popped by each word load
	word_fifo #(.DEPTH(`TX_FIFO_DEPTH)) tx_fifo_i (
		.clk(clk), .rst(rst), .push_i(tx_push_i), .data_i(tx_data_i), .pop_i(load_word_w),
		.data_o(tx_word_w), .full_o(tx_full_o), .empty_o(tx_empty_w)
	);

endmodule

/* rtl/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
	parameter int DEPTH = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        push_i,
	input  logic [31:0] data_i,
	input  logic        pop_i,
	output logic [31:0] data_o,
	output logic        full_o,
	output logic        empty_o
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [31:0]   mem_q [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [CW-1:0] count_q;
	logic          do_push_w;
	logic          do_pop_w;

	assign full_o    = (count_q == CW'(DEPTH));
	assign empty_o   = (count_q == '0);
	assign do_push_w = push_i && !full_o;   // Dropped when full
	assign do_pop_w  = pop_i && !empty_o;
	assign data_o    = mem_q[rd_ptr_q];     // Head, valid while not empty

	always_ff @(posedge clk) begin
		if (do_push_w)
			mem_q[wr_ptr_q] <= data_i;
	end

	// ---------------------------------------------------------------------
	// Pointers and occupancy
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push_w)
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop_w)
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			case ({do_push_w, do_pop_w})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

/* verif/i2c_master_bfm.sv */
`timescale 1ns/1ps

module i2c_master_bfm #(
	parameter int BIT_CLKS = 40
) (
	input  logic clk,
	input  logic sda_i,
	output logic scl_o,
	output logic sda_oe_o
);
	localparam int QTR = BIT_CLKS / 4;

	int collide_bit;  // Read bit pulled low by force, -1 for none

	initial begin
		scl_o       = 1'b1;
		sda_oe_o    = 1'b0;
		collide_bit = -1;
	end

	// Waits n rising edges, then steps just past the last one
	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// ---------------------------------------------------------------------
	// Bit level
	// ---------------------------------------------------------------------
	// One SCL period, SDA set while SCL is low and sampled mid-high
	task automatic clock_bit(input logic pull, output logic level);
		sda_oe_o = pull;
		wait_clocks(QTR);
		scl_o = 1'b1;
		wait_clocks(QTR);
		level = sda_i;
		wait_clocks(QTR);
		scl_o = 1'b0;
		wait_clocks(QTR);
	endtask

	task automatic send_start();
		sda_oe_o = 1'b1;   // SDA falls while SCL is high
		wait_clocks(2 * QTR);
		scl_o = 1'b0;
		wait_clocks(QTR);
	endtask

	task automatic send_stop();
		sda_oe_o = 1'b1;
		wait_clocks(QTR);
		scl_o = 1'b1;
		wait_clocks(2 * QTR);
		sda_oe_o = 1'b0;   // SDA rises while SCL is high
		wait_clocks(2 * QTR);
	endtask

	// ---------------------------------------------------------------------
	// Byte level
	// ---------------------------------------------------------------------
	task automatic write_byte(input logic [7:0] data, output logic acked);
		logic level;
		for (int i = 7; i >= 0; i--)
			clock_bit(!data[i], level);
		clock_bit(1'b0, level);   // Slave ACK slot
		acked = !level;
	endtask

	// ack high pulls SDA low in the ninth bit
	task automatic read_byte(input logic ack, output logic [7:0] data);
		logic level;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(i == collide_bit, level);
			data[i] = level;
		end
		clock_bit(ack, level);
	endtask

endmodule

/* verif/i2c_slave_tb.sv */
`timescale 1ns/1ps
`include "i2c_slave_cfg.svh"

module i2c_slave_tb;
	localparam int         BIT_CLKS     = 40;
	localparam int         N_TESTS      = 6;
	localparam int         TIMEOUT_CLKS = N_TESTS * 12 * 9 * BIT_CLKS * 2;
	localparam int         PULSE_WINDOW = `I2C_GLITCH + 6;  // Filter delay and slack
	localparam logic [6:0] OWN_ADDR     = 7'h3a;
	localparam logic [6:0] OTHER_ADDR   = 7'h15;

	logic        clk;
	logic        rst;
	logic        scl_bus;
	logic        sda_bus;
	logic        bfm_pull;
	logic        rx_pop;
	logic        tx_push;
	logic [31:0] tx_data;
	logic        sda_oe;
	logic [31:0] rx_data;
	logic        rx_empty;
	logic        tx_full;
	logic        wr_done;
	logic        rd_done;
	logic        rd_err;
	logic [31:0] rand_state;
	logic [31:0] exp_q[$];       // Words written but not yet popped
	logic        watch_release;
	logic        scl_prev;
	logic        sda_prev;
	int          cyc;
	int          stop_cyc;
	int          rise_cyc;
	int          wr_done_cnt;
	int          rd_done_cnt;
	int          rd_err_cnt;
	int          err_cnt;
	int          test_mark;
	int          pass_cnt;
	int          fail_cnt;

	// Pull-up that goes low when either side pulls
	assign sda_bus = !(bfm_pull || sda_oe);

	i2c_slave_top dut_i (
		.clk(clk), .rst(rst), .scl_i(scl_bus), .sda_i(sda_bus), .slave_addr_i(OWN_ADDR),
		.rx_pop_i(rx_pop), .tx_push_i(tx_push), .tx_data_i(tx_data), .sda_oe_o(sda_oe),
		.rx_data_o(rx_data), .rx_empty_o(rx_empty), .tx_full_o(tx_full),
		.wr_done_o(wr_done), .rd_done_o(rd_done), .rd_err_o(rd_err)
	);

	i2c_master_bfm #(.BIT_CLKS(BIT_CLKS)) bfm_i (
		.clk(clk), .sda_i(sda_bus), .scl_o(scl_bus), .sda_oe_o(bfm_pull)
	);

	always #5 clk = !clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == TIMEOUT_CLKS) begin
			$display("Run stopped after %0d clocks before the tests finished", cyc);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Bus events and pulse counts taken mid-cycle
	always @(negedge clk) begin
		if (scl_bus && !scl_prev)
			rise_cyc = cyc;
		if (scl_bus && sda_bus && !sda_prev)
			stop_cyc = cyc;
		scl_prev = scl_bus;
		sda_prev = sda_bus;
		if (wr_done)
			wr_done_cnt++;
		if (rd_done)
			rd_done_cnt++;
		if (rd_err) begin
			rd_err_cnt++;
			watch_release = 1'b1;
		end
	end

	// ---------------------------------------------------------------------
	// Assertions
	// ---------------------------------------------------------------------
	assert property (@(posedge clk) rst |=> (!sda_oe && rx_empty))
		else note_error("SDA pulled or rx FIFO not empty after reset");
	assert property (@(posedge clk) disable iff (rst) wr_done |=> !wr_done)
		else note_error("wr_done_o stayed high for more than one cycle");
	assert property (@(posedge clk) disable iff (rst) rd_done |=> !rd_done)
		else note_error("rd_done_o stayed high for more than one cycle");
	assert property (@(posedge clk) disable iff (rst) rd_err |=> !rd_err)
		else note_error("rd_err_o stayed high for more than one cycle");
	assert property (@(posedge clk) wr_done |-> (cyc - stop_cyc) <= PULSE_WINDOW)
		else note_error("wr_done_o came too long after STOP");
	assert property (@(posedge clk) rd_done |-> (cyc - rise_cyc) <= PULSE_WINDOW)
		else note_error("rd_done_o came too long after the NACK clock");
	assert property (@(posedge clk) rd_err |-> (cyc - rise_cyc) <= PULSE_WINDOW)
		else note_error("rd_err_o came too long after the overwritten bit");
	assert property (@(posedge clk) disable iff (rst) watch_release |-> !sda_oe)
		else note_error("slave pulled SDA again after losing the bus");

	// ---------------------------------------------------------------------
	// Helpers
	// ---------------------------------------------------------------------
	task automatic note_error(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want)
			else note_error($sformatf("Fail %s: got %h, expected %h", name, got, want));
	endtask

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic push_tx(input logic [31:0] word);
		tx_data = word;
		tx_push = 1'b1;
		step();
		tx_push = 1'b0;
	endtask

	// Pops every rx word and compares it with the oldest expected one
	task automatic drain_rx();
		while (!rx_empty) begin
			if (exp_q.size() > 0)
				check_value("rx_data_o", rx_data, exp_q.pop_front());
			else
				note_error("rx FIFO holds a word that was never written");
			rx_pop = 1'b1;
			step();
			rx_pop = 1'b0;
		end
		assert (exp_q.size() == 0)
			else note_error("rx FIFO ran empty before all written words arrived");
		exp_q.delete();
	endtask

	task automatic write_words(input logic [6:0] addr, input int n_words,
		input logic expect_ack);
		logic        ack;
		logic [31:0] word;
		int          done_before;
		done_before = wr_done_cnt;
		bfm_i.send_start();
		bfm_i.write_byte({addr, 1'b0}, ack);
		check_value("write address ACK", ack, expect_ack);
		if (ack) begin
			for (int k = 0; k < n_words; k++) begin
				word = next_random();
				exp_q.push_back(word);
				for (int b = 3; b >= 0; b--) begin
					bfm_i.write_byte(word[8 * b +: 8], ack);
					check_value("data byte ACK", ack, 1'b1);
				end
			end
		end
		bfm_i.send_stop();
		check_value("wr_done_o pulse count", wr_done_cnt - done_before, expect_ack);
	endtask

	// Collision mode reads one byte and overwrites its bit 5
	task automatic read_words(input int n_words, input logic expect_ack,
		input logic collide);
		logic        ack;
		logic [7:0]  got;
		logic [31:0] word;
		logic [31:0] words[$];
		int          done_before;
		int          err_before;
		for (int k = 0; k < n_words; k++) begin
			word = collide ? (next_random() | 32'h2000_0000) : next_random();
			words.push_back(word);
			push_tx(word);
		end
		check_value("tx_full_o", tx_full, n_words >= `TX_FIFO_DEPTH);
		done_before = rd_done_cnt;
		err_before  = rd_err_cnt;
		bfm_i.send_start();
		bfm_i.write_byte({OWN_ADDR, 1'b1}, ack);
		check_value("read address ACK", ack, expect_ack);
		if (ack && collide) begin
			bfm_i.collide_bit = 5;
			bfm_i.read_byte(1'b0, got);
			bfm_i.collide_bit = -1;
			// Bits after the lost one read high once the slave lets go
			check_value("byte after collision", got, {words[0][31:30], 1'b0, 5'h1f});
		end else if (ack) begin
			for (int j = 0; j < 4 * n_words; j++) begin
				bfm_i.read_byte(j != 4 * n_words - 1, got);
				word = words[j / 4];
				check_value("read byte", got, word[8 * (3 - j % 4) +: 8]);
			end
		end
		bfm_i.send_stop();
		if (ack && collide)
			check_value("rd_err_o pulse count", rd_err_cnt - err_before, 1);
		else if (ack)
			check_value("rd_done_o pulse count", rd_done_cnt - done_before, 1);
		watch_release = 1'b0;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == test_mark) begin
			pass_cnt++;
			$display("Test %0d %s: ok", pass_cnt + fail_cnt, name);
		end else begin
			fail_cnt++;
			$display("Test %0d %s: %0d errors", pass_cnt + fail_cnt, name, err_cnt - test_mark);
		end
		test_mark = err_cnt;
	endtask

	// ---------------------------------------------------------------------
	// Test sequence
	// ---------------------------------------------------------------------
	initial begin
		clk           = 1'b0;
		rst           = 1'b1;
		rx_pop        = 1'b0;
		tx_push       = 1'b0;
		tx_data       = 32'h0;
		rand_state    = 32'h5c76_5917;
		watch_release = 1'b0;
		scl_prev      = 1'b1;
		sda_prev      = 1'b1;
		cyc           = 0;
		stop_cyc      = 0;
		rise_cyc      = 0;
		wr_done_cnt   = 0;
		rd_done_cnt   = 0;
		rd_err_cnt    = 0;
		err_cnt       = 0;
		test_mark     = 0;
		pass_cnt      = 0;
		fail_cnt      = 0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (10) step();

		write_words(OWN_ADDR, 3, 1'b1);
		drain_rx();
		end_test("write of three words");

		write_words(OTHER_ADDR, 1, 1'b0);
		check_value("rx_empty_o", rx_empty, 1'b1);
		end_test("write to another address");

		read_words(3, 1'b1, 1'b0);
		end_test("read of twelve bytes");

		write_words(OWN_ADDR, `RX_FIFO_DEPTH, 1'b1);
		write_words(OWN_ADDR, 1, 1'b0);   // rx FIFO full
		read_words(0, 1'b0, 1'b0);        // tx FIFO empty
		drain_rx();
		end_test("back-pressure NACKs");

		write_words(`I2C_GCALL_ADDR, 1, 1'b1);
		drain_rx();
		end_test("general call write");

		read_words(1, 1'b1, 1'b1);
		end_test("read collision");

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (err_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
